// File: hw/c64_audio_pkg.sv
/*
 * C64 audio path shared definitions
 * Sample types, DigiMax channel count and modes, compressor defaults,
 * configuration register map and mixer bit positions
 */
package c64_audio_pkg;

	// ====================
	// Sample types
	// ====================

	// Mixed output and FM sample
	typedef logic signed [15:0] sample_t;

	// Raw SID voice sum
	typedef logic signed [17:0] sid_sample_t;

	// One DigiMax channel, a byte kept in 9 bits for the pair sums
	typedef logic [8:0] dac_t;

	localparam int DAC_CHANNELS = 4;

	// ====================
	// FM compressor
	// ====================

	// Slope divisor above the knee
	localparam int COMP_F_DEFAULT = 4;
	// Gain below the knee
	localparam int COMP_A_DEFAULT = 2;

	// ====================
	// Configuration
	// ====================

	// DigiMax cartridge location, value 3 is not a legal setting
	typedef enum logic [1:0] {
		DIGIMAX_OFF  = 2'd0,
		DIGIMAX_DE00 = 2'd1,
		DIGIMAX_DF00 = 2'd2
	} digimax_mode_e;

	localparam logic [1:0] CFG_ADDR_DIGIMAX  = 2'd0;
	localparam logic [1:0] CFG_ADDR_TAPE_SND = 2'd1;
	localparam logic [1:0] CFG_ADDR_MIX      = 2'd2;

	// Bit position of the cassette tone in the mix sum
	localparam int TAPE_TONE_SHIFT = 10;
	// Bit position of the DigiMax pair sum in the mix
	localparam int DAC_SHIFT = 6;

endpackage

// File: hw/audio_cfg_regs.sv
/*
 * Audio configuration registers
 * Holds the DigiMax mode, the tape sound enable and the stereo mix
 * setting, written one at a time through a simple strobe interface
 */
module audio_cfg_regs (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         cfg_wr_i,
	input  logic [1:0]                   cfg_addr_i,
	input  logic [7:0]                   cfg_data_i,
	output c64_audio_pkg::digimax_mode_e digimax_mode_o,
	output logic                         tape_snd_en_o,
	output logic [1:0]                   audio_mix_o
);

	logic digimax_legal;

	// Value 3 has no cartridge location behind it
	assign digimax_legal = (cfg_data_i[1:0] != 2'd3);

	// ====================
	// Register writes
	// ====================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			digimax_mode_o <= c64_audio_pkg::DIGIMAX_OFF;
			tape_snd_en_o  <= 1'b0;
			audio_mix_o    <= 2'd0;
		end else if (cfg_wr_i) begin
			case (cfg_addr_i)
				c64_audio_pkg::CFG_ADDR_DIGIMAX: begin
					// Keep the previous mode on an illegal value
					if (digimax_legal) begin
						digimax_mode_o <= c64_audio_pkg::digimax_mode_e'(cfg_data_i[1:0]);
					end
				end
				c64_audio_pkg::CFG_ADDR_TAPE_SND: begin
					tape_snd_en_o <= cfg_data_i[0];
				end
				c64_audio_pkg::CFG_ADDR_MIX: begin
					audio_mix_o <= cfg_data_i[1:0];
				end
				default: begin
					// Address 3 is unmapped
					audio_mix_o <= audio_mix_o;
				end
			endcase
		end
	end

	// ====================
	// Checks
	// ====================

	// The DigiMax decoder only knows the three enumerated modes
	mode_legal_a: assert property (
		@(posedge clk_sys) disable iff (RESET)
		digimax_mode_o != 2'd3
	) else $error("DigiMax mode holds the illegal value 3");

endmodule

// File: hw/digimax_dac.sv
/*
 * DigiMax four channel DAC cartridge
 * Catches CPU writes in the IO1 or IO2 area, keeps the four channel
 * bytes and guesses a mono, stereo or four channel layout
 */
module digimax_dac (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  c64_audio_pkg::digimax_mode_e digimax_mode_i,
	input  logic                         io_e_i,
	input  logic                         io_f_i,
	input  logic                         cpu_we_i,
	input  logic [2:0]                   cpu_addr_i,
	input  logic [7:0]                   cpu_data_i,
	output logic [9:0]                   dac_l_o,
	output logic [9:0]                   dac_r_o
);

	c64_audio_pkg::dac_t dac_ch [c64_audio_pkg::DAC_CHANNELS];
	logic [c64_audio_pkg::DAC_CHANNELS-1:0] act_q;

	logic io_e_q;
	logic io_f_q;
	logic ioe_we;
	logic iof_we;
	logic sel_we;

	// ====================
	// Write strobes
	// ====================

	// One strobe per rising area select with the CPU writing
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			io_e_q <= 1'b0;
			io_f_q <= 1'b0;
			ioe_we <= 1'b0;
			iof_we <= 1'b0;
		end else begin
			io_e_q <= io_e_i;
			io_f_q <= io_f_i;
			ioe_we <= ~io_e_q & io_e_i & cpu_we_i;
			iof_we <= ~io_f_q & io_f_i & cpu_we_i;
		end
	end

	always_comb begin
		case (digimax_mode_i)
			c64_audio_pkg::DIGIMAX_DE00: sel_we = ioe_we;
			c64_audio_pkg::DIGIMAX_DF00: sel_we = iof_we;
			default:                     sel_we = 1'b0;
		endcase
	end

	// ====================
	// Channel registers
	// ====================

	// Addresses with bit 2 set belong to other hardware in the area
	always_ff @(posedge clk_sys) begin
		if (RESET || digimax_mode_i == c64_audio_pkg::DIGIMAX_OFF) begin
			for (int i = 0; i < c64_audio_pkg::DAC_CHANNELS; i++) begin
				dac_ch[i] <= '0;
			end
			act_q <= '0;
		end else if (sel_we && !cpu_addr_i[2]) begin
			dac_ch[cpu_addr_i[1:0]] <= {1'b0, cpu_data_i};
			// A channel counts as used once it sees a non-zero byte
			if (cpu_data_i != 8'd0) begin
				act_q[cpu_addr_i[1:0]] <= 1'b1;
			end
		end
	end

	// ====================
	// Layout guess
	// ====================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dac_l_o <= '0;
			dac_r_o <= '0;
		end else if (act_q < 2) begin
			// Mono with channel 0 on both sides
			dac_l_o <= {1'b0, dac_ch[0]} + {1'b0, dac_ch[0]};
			dac_r_o <= {1'b0, dac_ch[0]} + {1'b0, dac_ch[0]};
		end else if (act_q == 2) begin
			// Stereo on channels 0 and 1 only
			dac_l_o <= {1'b0, dac_ch[1]} + {1'b0, dac_ch[1]};
			dac_r_o <= {1'b0, dac_ch[0]} + {1'b0, dac_ch[0]};
		end else begin
			dac_l_o <= {1'b0, dac_ch[1]} + {1'b0, dac_ch[2]};
			dac_r_o <= {1'b0, dac_ch[0]} + {1'b0, dac_ch[3]};
		end
	end

	// A cartridge switched off is silent two cycles later
	off_silent_a: assert property (
		@(posedge clk_sys) disable iff (RESET)
		($past(digimax_mode_i, 2) == c64_audio_pkg::DIGIMAX_OFF) |->
			(dac_l_o == '0 && dac_r_o == '0)
	) else $error("DigiMax output not silent while the cartridge is off");

endmodule

// File: hw/fm_compressor.sv
/*
 * FM sample compressor
 * Takes one eighth off the OPL2 sample, then applies a soft knee
 * curve to the magnitude and puts the sign back
 */
module fm_compressor #(
	parameter int COMP_F = c64_audio_pkg::COMP_F_DEFAULT,
	parameter int COMP_A = c64_audio_pkg::COMP_A_DEFAULT
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  c64_audio_pkg::sample_t fm_sample_i,
	output c64_audio_pkg::sample_t comp_sample_o
);

	// Knee sits one above the exact crossover so the top never overflows
	localparam int COMP_X = ((32767 * (COMP_F - 1)) / ((COMP_F * COMP_A) - 1)) + 1;
	localparam logic [16:0] KNEE_X   = 17'(COMP_X);
	localparam logic [16:0] OFFSET_B = 17'(COMP_X * COMP_A);
	localparam logic [16:0] GAIN_A   = 17'(COMP_A);
	localparam logic [16:0] SLOPE_F  = 17'(COMP_F);

	c64_audio_pkg::sample_t stage1_q;
	logic [16:0] mag;
	logic [16:0] comp_mag;
	c64_audio_pkg::sample_t comp_signed;

	// Magnitude curve, linear gain below the knee and flat slope above
	always_comb begin
		mag = stage1_q[15] ? 17'(-stage1_q) : {1'b0, stage1_q};
		if (mag < KNEE_X) begin
			comp_mag = mag * GAIN_A;
		end else begin
			comp_mag = ((mag - KNEE_X) / SLOPE_F) + OFFSET_B;
		end
		comp_signed = stage1_q[15] ? -comp_mag[15:0] : comp_mag[15:0];
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			stage1_q      <= '0;
			comp_sample_o <= '0;
		end else begin
			stage1_q      <= fm_sample_i - (fm_sample_i >>> 3);
			comp_sample_o <= comp_signed;
		end
	end

	// Compression changes level only, never polarity
	sign_kept_a: assert property (
		@(posedge clk_sys) disable iff (RESET)
		(stage1_q != 0) |=> (comp_sample_o[15] == $past(stage1_q[15]))
	) else $error("FM compressor flipped the sample sign");

endmodule

// File: hw/audio_mixer.sv
/*
 * Audio output mixer
 * Sums FM, SID, DigiMax and the cassette tone per side into 17 bits
 * and clips the result to a 16-bit signed sample
 */
module audio_mixer (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  c64_audio_pkg::sample_t     comp_sample_i,
	input  c64_audio_pkg::sid_sample_t sid_l_i,
	input  c64_audio_pkg::sid_sample_t sid_r_i,
	input  logic [9:0]                 dac_l_i,
	input  logic [9:0]                 dac_r_i,
	input  logic                       tape_snd_en_i,
	input  logic                       cass_motor_i,
	input  logic                       tap_play_i,
	input  logic                       cass_data_i,
	output c64_audio_pkg::sample_t     audio_l_o,
	output c64_audio_pkg::sample_t     audio_r_o
);

	logic        tape_tone;
	logic [16:0] sum_l_q;
	logic [16:0] sum_r_q;

	// Tone only while the tape plays with the motor line released
	assign tape_tone = ~cass_motor_i & tap_play_i & tape_snd_en_i & cass_data_i;

	// Four terms in two's complement, wrapping at 17 bits
	function automatic logic [16:0] mix_sum(
		input c64_audio_pkg::sample_t     fm,
		input c64_audio_pkg::sid_sample_t sid,
		input logic [9:0]                 dac,
		input logic                       tone
	);
		logic [16:0] fm_term;
		logic [16:0] sid_term;
		logic [16:0] dac_term;
		logic [16:0] tone_term;
		fm_term   = {fm[15], fm};
		sid_term  = {sid[17], sid[17:2]};
		dac_term  = 17'(dac) << c64_audio_pkg::DAC_SHIFT;
		tone_term = 17'(tone) << c64_audio_pkg::TAPE_TONE_SHIFT;
		return fm_term + sid_term + dac_term + tone_term;
	endfunction

	// Top two bits disagree when the sum left the 16-bit range
	function automatic c64_audio_pkg::sample_t saturate(input logic [16:0] sum);
		if (sum[16] != sum[15]) begin
			return {sum[16], {15{~sum[16]}}};
		end
		return sum[15:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			sum_l_q   <= '0;
			sum_r_q   <= '0;
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			sum_l_q   <= mix_sum(comp_sample_i, sid_l_i, dac_l_i, tape_tone);
			sum_r_q   <= mix_sum(comp_sample_i, sid_r_i, dac_r_i, tape_tone);
			audio_l_o <= saturate(sum_l_q);
			audio_r_o <= saturate(sum_r_q);
		end
	end

	// Every source upstream must come out of reset with a known value
	out_known_a: assert property (
		@(posedge clk_sys) disable iff (RESET)
		!$isunknown({audio_l_o, audio_r_o})
	) else $error("Audio output unknown after reset");

endmodule

// File: hw/c64_audio_top.sv
/*
 * C64 audio output path
 * Configuration registers, DigiMax cartridge, FM compressor and the
 * output mixer joined into one block
 */
module c64_audio_top (
	input  logic                       clk_sys,
	input  logic                       RESET,

	// Configuration writes
	input  logic                       cfg_wr_i,
	input  logic [1:0]                 cfg_addr_i,
	input  logic [7:0]                 cfg_data_i,

	// CPU bus for the DigiMax
	input  logic                       io_e_i,
	input  logic                       io_f_i,
	input  logic                       cpu_we_i,
	input  logic [2:0]                 cpu_addr_i,
	input  logic [7:0]                 cpu_data_i,

	// Sources
	input  c64_audio_pkg::sample_t     fm_sample_i,
	input  c64_audio_pkg::sid_sample_t sid_l_i,
	input  c64_audio_pkg::sid_sample_t sid_r_i,
	input  logic                       cass_motor_i,
	input  logic                       tap_play_i,
	input  logic                       cass_data_i,

	output c64_audio_pkg::sample_t     audio_l_o,
	output c64_audio_pkg::sample_t     audio_r_o,
	output logic [1:0]                 audio_mix_o
);

	c64_audio_pkg::digimax_mode_e digimax_mode;
	logic                         tape_snd_en;
	logic [9:0]                   dac_l;
	logic [9:0]                   dac_r;
	c64_audio_pkg::sample_t       comp_sample;

	audio_cfg_regs cfg_regs_inst (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.cfg_wr_i       (cfg_wr_i),
		.cfg_addr_i     (cfg_addr_i),
		.cfg_data_i     (cfg_data_i),
		.digimax_mode_o (digimax_mode),
		.tape_snd_en_o  (tape_snd_en),
		.audio_mix_o    (audio_mix_o)
	);

	digimax_dac digimax_inst (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.digimax_mode_i (digimax_mode),
		.io_e_i         (io_e_i),
		.io_f_i         (io_f_i),
		.cpu_we_i       (cpu_we_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_data_i     (cpu_data_i),
		.dac_l_o        (dac_l),
		.dac_r_o        (dac_r)
	);

	fm_compressor #(
		.COMP_F (c64_audio_pkg::COMP_F_DEFAULT),
		.COMP_A (c64_audio_pkg::COMP_A_DEFAULT)
	) fm_comp_inst (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.fm_sample_i   (fm_sample_i),
		.comp_sample_o (comp_sample)
	);

	audio_mixer mixer_inst (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.comp_sample_i (comp_sample),
		.sid_l_i       (sid_l_i),
		.sid_r_i       (sid_r_i),
		.dac_l_i       (dac_l),
		.dac_r_i       (dac_r),
		.tape_snd_en_i (tape_snd_en),
		.cass_motor_i  (cass_motor_i),
		.tap_play_i    (tap_play_i),
		.cass_data_i   (cass_data_i),
		.audio_l_o     (audio_l_o),
		.audio_r_o     (audio_r_o)
	);

endmodule

// File: sim/audio_model.svh
/*
 * Reference models for the audio path testbench
 * Compressor curve, DigiMax layout, tape tone gate, mixer sum with
 * clipping, and the stimulus LFSR
 */
`ifndef AUDIO_MODEL_SVH
`define AUDIO_MODEL_SVH

// 16-bit Fibonacci LFSR with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// FM minus one eighth, then the soft knee on the magnitude
function automatic int compress_fm(input int fm);
	int f;
	int a;
	int knee;
	int s;
	int mag;
	int c;
	f = c64_audio_pkg::COMP_F_DEFAULT;
	a = c64_audio_pkg::COMP_A_DEFAULT;
	knee = 32767 * (f - 1) / (f * a - 1) + 1;
	s = fm - (fm >>> 3);
	mag = (s < 0) ? -s : s;
	if (mag < knee) begin
		c = mag * a;
	end else begin
		c = (mag - knee) / f + knee * a;
	end
	return (s < 0) ? -c : c;
endfunction

// One side of the DigiMax layout guess
function automatic int digimax_side(input bit left, input int ch [4],
	input logic [3:0] mask);
	if (mask < 4'd2) begin
		return 2 * ch[0];
	end
	if (mask == 4'd2) begin
		return left ? 2 * ch[1] : 2 * ch[0];
	end
	return left ? ch[1] + ch[2] : ch[0] + ch[3];
endfunction

function automatic bit tape_tone_on(input bit en, input bit motor, input bit play,
	input bit data);
	return en && !motor && play && data;
endfunction

// Four terms in a 17-bit adder, then clipped to 16 bits
function automatic int mix_and_clip(input int comp, input int sid, input int dac,
	input bit tone);
	int sum;
	sum = comp + (sid >>> 2) + (dac << c64_audio_pkg::DAC_SHIFT);
	sum = sum + (tone ? (1 << c64_audio_pkg::TAPE_TONE_SHIFT) : 0);
	sum = int'((sum + 65536) & 32'h0001_FFFF) - 65536;
	if (sum > 32767) begin
		return 32767;
	end
	if (sum < -32768) begin
		return -32768;
	end
	return sum;
endfunction

`endif

// File: sim/tb_c64_audio.sv
/*
 * Testbench for the C64 audio output path
 * Directed and random stimulus checked against reference models
 */
module tb_c64_audio;
	timeunit 1ns;
	timeprecision 100ps;

	`include "audio_model.svh"

	localparam int NUM_TESTS      = 6;
	localparam int VECS_PER_TEST  = 32;
	localparam int CYCLES_PER_VEC = 20;

	logic clk_sys;
	logic RESET = 1'b1;
	logic cfg_wr_i = 1'b0;
	logic [1:0] cfg_addr_i = '0;
	logic [7:0] cfg_data_i = '0;
	logic io_e_i = 1'b0;
	logic io_f_i = 1'b0;
	logic cpu_we_i = 1'b0;
	logic [2:0] cpu_addr_i = '0;
	logic [7:0] cpu_data_i = '0;
	c64_audio_pkg::sample_t fm_sample_i = '0;
	c64_audio_pkg::sid_sample_t sid_l_i = '0;
	c64_audio_pkg::sid_sample_t sid_r_i = '0;
	logic cass_motor_i = 1'b0;
	logic tap_play_i = 1'b0;
	logic cass_data_i = 1'b0;
	c64_audio_pkg::sample_t audio_l_o;
	c64_audio_pkg::sample_t audio_r_o;
	logic [1:0] audio_mix_o;

	// Expected DUT state tracked by the stimulus tasks
	int m_ch [4] = '{default: 0};
	logic [3:0] m_mask = '0;
	logic [1:0] m_mode = '0;
	logic m_tape_en = 1'b0;
	logic [1:0] m_mix = '0;

	c64_audio_pkg::sample_t fm_corner [6] = '{16'sh0000, 16'sh7FFF, 16'sh8000,
		16'shFFFF, 16'sd16049, 16'sd16050};
	logic [15:0] lfsr_q = 16'd59784;
	logic check_req = 1'b0;
	int err_count = 0;
	int total_vecs = 0;
	int test_num = 1;
	int test_vecs = 0;
	int test_errs = 0;
	int exp_l;
	int exp_r;
	int exp_comp;
	bit exp_tone;

	c64_audio_top c64_audio_top_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ====================
	// Stimulus helpers
	// ====================

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic logic [7:0] nonzero_byte();
		return 8'(rand_bits(8)) | 8'h01;
	endfunction

	task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		cfg_wr_i   <= 1'b1;
		cfg_addr_i <= addr;
		cfg_data_i <= data;
		@(posedge clk_sys);
		cfg_wr_i <= 1'b0;
		if (addr == c64_audio_pkg::CFG_ADDR_DIGIMAX && data[1:0] != 2'd3) begin
			m_mode = data[1:0];
		end
		if (addr == c64_audio_pkg::CFG_ADDR_TAPE_SND) begin
			m_tape_en = data[0];
		end
		if (addr == c64_audio_pkg::CFG_ADDR_MIX) begin
			m_mix = data[1:0];
		end
		// Cartridge off wipes every channel
		if (m_mode == c64_audio_pkg::DIGIMAX_OFF) begin
			m_ch = '{default: 0};
			m_mask = '0;
		end
	endtask

	// Address and data stay on the bus until the next write
	task automatic cpu_write(input bit use_f, input logic [2:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		io_e_i     <= !use_f;
		io_f_i     <= use_f;
		cpu_we_i   <= 1'b1;
		cpu_addr_i <= addr;
		cpu_data_i <= data;
		@(posedge clk_sys);
		io_e_i   <= 1'b0;
		io_f_i   <= 1'b0;
		cpu_we_i <= 1'b0;
		if (((m_mode == c64_audio_pkg::DIGIMAX_DE00 && !use_f) ||
			(m_mode == c64_audio_pkg::DIGIMAX_DF00 && use_f)) && !addr[2]) begin
			m_ch[addr[1:0]] = int'(data);
			if (data != 8'd0) begin
				m_mask[addr[1:0]] = 1'b1;
			end
		end
	endtask

	task automatic drive_sources(input c64_audio_pkg::sample_t fm,
		input c64_audio_pkg::sid_sample_t sl, input c64_audio_pkg::sid_sample_t sr);
		@(posedge clk_sys);
		fm_sample_i <= fm;
		sid_l_i     <= sl;
		sid_r_i     <= sr;
	endtask

	task automatic settle_and_check();
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		check_req = 1'b1;
		wait (!check_req);
	endtask

	task automatic finish_test(input string name);
		$display("test %0d %s: %0d checks, %0d errors", test_num, name, test_vecs, test_errs);
		test_num++;
		test_vecs = 0;
		test_errs = 0;
	endtask

	task automatic report_mismatch(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		$display("ERR at %0d ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
		err_count++;
		test_errs++;
	endtask

	// ====================
	// Compare
	// ====================

	always begin
		wait (check_req);
		exp_tone = tape_tone_on(m_tape_en, cass_motor_i, tap_play_i, cass_data_i);
		exp_comp = compress_fm(int'(fm_sample_i));
		exp_l = mix_and_clip(exp_comp, int'(sid_l_i),
			digimax_side(1'b1, m_ch, m_mask), exp_tone);
		exp_r = mix_and_clip(exp_comp, int'(sid_r_i),
			digimax_side(1'b0, m_ch, m_mask), exp_tone);
		test_vecs++;
		total_vecs++;
		if (audio_l_o !== c64_audio_pkg::sample_t'(exp_l)) begin
			report_mismatch("left output", audio_l_o, 16'(exp_l));
		end
		if (audio_r_o !== c64_audio_pkg::sample_t'(exp_r)) begin
			report_mismatch("right output", audio_r_o, 16'(exp_r));
		end
		if (audio_mix_o !== m_mix) begin
			report_mismatch("mix setting", {14'd0, audio_mix_o}, {14'd0, m_mix});
		end
		check_req = 1'b0;
	end

	initial begin
		repeat (NUM_TESTS * VECS_PER_TEST * CYCLES_PER_VEC) @(posedge clk_sys);
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

	// ====================
	// Tests
	// ====================

	initial begin
		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;
		settle_and_check();
		finish_test("reset state");

		for (int i = 0; i < 24; i++) begin
			drive_sources('0, c64_audio_pkg::sid_sample_t'(rand_bits(18)),
				c64_audio_pkg::sid_sample_t'(rand_bits(18)));
			settle_and_check();
		end
		finish_test("SID only");

		// Corners first with the knee between inputs 16049 and 16050
		for (int i = 0; i < 26; i++) begin
			drive_sources((i < 6) ? fm_corner[i] : c64_audio_pkg::sample_t'(rand_bits(16)),
				'0, '0);
			settle_and_check();
		end
		drive_sources('0, '0, '0);
		finish_test("FM compressor");

		cfg_write(c64_audio_pkg::CFG_ADDR_DIGIMAX, 8'd1);
		cpu_write(1'b0, 3'd0, nonzero_byte());
		settle_and_check();
		cfg_write(c64_audio_pkg::CFG_ADDR_DIGIMAX, 8'd0);
		cfg_write(c64_audio_pkg::CFG_ADDR_DIGIMAX, 8'd1);
		cpu_write(1'b0, 3'd1, nonzero_byte());
		settle_and_check();
		for (int ch = 0; ch < 4; ch++) begin
			cpu_write(1'b0, 3'(ch), nonzero_byte());
		end
		settle_and_check();
		// Wrong area and bit 2 set must both be ignored
		cpu_write(1'b1, 3'd2, nonzero_byte());
		cpu_write(1'b0, 3'd4, nonzero_byte());
		settle_and_check();
		cfg_write(c64_audio_pkg::CFG_ADDR_DIGIMAX, 8'd0);
		cpu_write(1'b0, 3'd0, nonzero_byte());
		cpu_write(1'b1, 3'd1, nonzero_byte());
		settle_and_check();
		cfg_write(c64_audio_pkg::CFG_ADDR_DIGIMAX, 8'd2);
		cpu_write(1'b0, 3'd0, nonzero_byte());
		settle_and_check();
		cpu_write(1'b1, 3'd0, nonzero_byte());
		settle_and_check();
		finish_test("DigiMax");

		cfg_write(c64_audio_pkg::CFG_ADDR_DIGIMAX, 8'd0);
		for (int k = 0; k < 16; k++) begin
			cfg_write(c64_audio_pkg::CFG_ADDR_TAPE_SND, {7'd0, k[3]});
			@(posedge clk_sys);
			cass_motor_i <= k[2];
			tap_play_i   <= k[1];
			cass_data_i  <= k[0];
			settle_and_check();
		end
		cfg_write(c64_audio_pkg::CFG_ADDR_TAPE_SND, 8'd0);
		cfg_write(c64_audio_pkg::CFG_ADDR_DIGIMAX, 8'd1);
		for (int ch = 0; ch < 4; ch++) begin
			cpu_write(1'b0, 3'(ch), 8'hFF);
		end
		drive_sources('0, 18'h1FFFF, 18'h1FFFF);
		settle_and_check();
		cfg_write(c64_audio_pkg::CFG_ADDR_DIGIMAX, 8'd0);
		drive_sources(16'sh8000, 18'h20000, 18'h20000);
		settle_and_check();
		drive_sources('0, '0, '0);
		finish_test("tape tone and clipping");

		for (int k = 0; k < 4; k++) begin
			cfg_write(c64_audio_pkg::CFG_ADDR_MIX, 8'(3 - k));
			settle_and_check();
		end
		cfg_write(c64_audio_pkg::CFG_ADDR_DIGIMAX, 8'd1);
		cfg_write(c64_audio_pkg::CFG_ADDR_DIGIMAX, 8'd3);
		cpu_write(1'b0, 3'd0, nonzero_byte());
		cpu_write(1'b1, 3'd1, nonzero_byte());
		settle_and_check();
		finish_test("config registers");

		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, total_vecs, err_count);
		if (err_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+sim
hw/c64_audio_pkg.sv
hw/audio_cfg_regs.sv
hw/digimax_dac.sv
hw/fm_compressor.sv
hw/audio_mixer.sv
hw/c64_audio_top.sv
sim/tb_c64_audio.sv

// File: run_sim.sh
#!/bin/sh
# Build the audio path testbench with Verilator, run it, and check the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_c64_audio -f compile.f -o tb_c64_audio
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_c64_audio > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
